// ==== common/osc_pkg.sv ====
`default_nettype none

package osc_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // raw ADC word, two LSBs unused on 14-bit parts
  localparam int unsigned ADC_RAW_W = 16;
  // calibrated sample
  localparam int unsigned SMP_W     = 14;
  // gain word
  localparam int unsigned CAL_MUL_W = 16;
  // gain binary point, 1<<14 is unity
  localparam int unsigned CAL_SHIFT = 14;
  // post-trigger length
  localparam int unsigned PLEN_W    = 16;

  //////////////////////////////////////////////////////////////////////
  // sample and calibration types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [SMP_W-1:0]     smp_t;
  typedef logic signed [CAL_MUL_W-1:0] cal_mul_t;

  // saturation limits
  localparam smp_t SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};
  localparam smp_t SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};

  // gain and offset pair
  typedef struct packed {
    cal_mul_t mul;
    smp_t     sum;
  } cal_t;

  //////////////////////////////////////////////////////////////////////
  // acquisition configuration
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    TRG_SW  = 1'b0,
    TRG_EXT = 1'b1
  } trg_src_t;

  // post_len of 0 behaves like 1
  typedef struct packed {
    trg_src_t          trg_src;
    logic [PLEN_W-1:0] post_len;
  } acq_cfg_t;

endpackage : osc_pkg

`default_nettype wire

// ==== src/adc_frontend.sv ====
`default_nettype none

module adc_frontend
  import osc_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // raw converter word
  input  logic [ADC_RAW_W-1:0] adc_dat_i,
  // gain and offset
  input  cal_t                 cal_i,
  // calibrated stream, 3 cycles behind adc_dat_i
  output smp_t                 smp_o
);

  //////////////////////////////////////////////////////////////////////
  // local widths
  //////////////////////////////////////////////////////////////////////

  // full product
  localparam int unsigned PROD_W = SMP_W + CAL_MUL_W;
  // product after binary point shift
  localparam int unsigned SHF_W  = PROD_W - CAL_SHIFT;
  // one guard bit for the offset add
  localparam int unsigned SUM_W  = SHF_W + 1;

  smp_t                    raw_q;
  logic signed [PROD_W-1:0] prod_q;
  logic signed [SHF_W-1:0]  prod_shf;
  logic signed [SUM_W-1:0]  sum_full;
  logic                     sum_ovf;

  //////////////////////////////////////////////////////////////////////
  // stage 1: input register
  //////////////////////////////////////////////////////////////////////

  // sign bit kept, magnitude bits inverted
  // bits 1:0 dropped
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_q <= '0;
    end else begin
      raw_q <= {adc_dat_i[ADC_RAW_W-1], ~adc_dat_i[ADC_RAW_W-2:2]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: gain
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
    end else begin
      // signed 14 x 16, both sign extended to product width
      prod_q <= raw_q * $signed(cal_i.mul);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 3: offset and saturation
  //////////////////////////////////////////////////////////////////////

  // arithmetic shift is just dropping the fraction bits
  assign prod_shf = prod_q[PROD_W-1:CAL_SHIFT];

  // offset sign extended to SUM_W
  assign sum_full = prod_shf + $signed(cal_i.sum);

  // out of range when bits above the sample MSB differ from it
  assign sum_ovf = (sum_full[SUM_W-1:SMP_W-1] != {(SUM_W-SMP_W+1){sum_full[SMP_W-1]}});

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else if (sum_ovf) begin
      // clip toward the sign of the full sum
      smp_o <= sum_full[SUM_W-1] ? SMP_MIN : SMP_MAX;
    end else begin
      smp_o <= sum_full[SMP_W-1:0];
    end
  end

endmodule : adc_frontend

`default_nettype wire

// ==== src/debounce.sv ====
`default_nettype none

module debounce #(
  // cycles a new level must hold
  parameter int unsigned DB_LEN = 16,
  // stability timer width
  parameter int unsigned DB_CW  = 8
) (
  input  logic adc_clk,
  input  logic top_rst,
  // asynchronous input
  input  logic din_i,
  // one cycle pulse per accepted rise
  output logic pos_o
);

  logic [1:0]       sync_q;
  logic             prev_q;
  logic [DB_CW-1:0] tmr_q;
  logic             lvl_q;
  logic             tmr_done;

  //////////////////////////////////////////////////////////////////////
  // synchronizer
  //////////////////////////////////////////////////////////////////////

  // two flops, then one more to spot changes
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], din_i};
      prev_q <= sync_q[1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stability timer
  //////////////////////////////////////////////////////////////////////

  // tmr_q counts cycles the synchronized level has held
  // saturates at DB_LEN
  assign tmr_done = (tmr_q == DB_CW'(DB_LEN));

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      tmr_q <= '0;
    end else if (sync_q[1] != prev_q) begin
      // level changed, this cycle is the first one
      tmr_q <= DB_CW'(1);
    end else if (!tmr_done) begin
      tmr_q <= tmr_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // accepted level and edge pulse
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      lvl_q <= 1'b0;
      pos_o <= 1'b0;
    end else begin
      // accept only a level that differs from the current one
      if (tmr_done && (prev_q != lvl_q)) begin
        lvl_q <= prev_q;
      end
      // rising edge only
      pos_o <= tmr_done && prev_q && !lvl_q;
    end
  end

endmodule : debounce

`default_nettype wire

// ==== acq/acq_counter.sv ====
`default_nettype none

module acq_counter
  import osc_pkg::*;
#(
  // time stamp width
  parameter int unsigned TW = 64
) (
  input  logic              adc_clk,
  input  logic              top_rst,
  // trigger, latch time stamp and load counter
  input  logic              trg_i,
  input  logic [PLEN_W-1:0] post_len_i,
  // decrement while capturing
  input  logic              cnt_en_i,
  output logic [TW-1:0]     trg_ts_o,
  // counter on its final value
  output logic              last_o
);

  logic [TW-1:0]     cts_q;
  logic [PLEN_W-1:0] cnt_q;

  //////////////////////////////////////////////////////////////////////
  // time stamps
  //////////////////////////////////////////////////////////////////////

  // free running, 0 in the first cycle out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cts_q    <= '0;
      trg_ts_o <= '0;
    end else begin
      cts_q <= cts_q + 1'b1;
      // value of the trigger cycle itself
      if (trg_i) begin
        trg_ts_o <= cts_q;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // post-trigger counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt_q <= '0;
    end else if (trg_i) begin
      cnt_q <= post_len_i;
    end else if (cnt_en_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // one left means this is the last sample
  assign last_o = (cnt_q == PLEN_W'(1));

endmodule : acq_counter

`default_nettype wire

// ==== acq/acq_fsm.sv ====
`default_nettype none

module acq_fsm
  import osc_pkg::*;
(
  input  logic              adc_clk,
  input  logic              top_rst,
  // control strobes
  input  logic              arm_i,
  input  logic              stop_i,
  // trigger sources
  input  logic              trg_sw_i,
  input  logic              trg_ext_i,
  // configuration, taken on arm
  input  acq_cfg_t          acq_cfg_i,
  // final count from acq_counter
  input  logic              last_i,
  // trigger accepted, latch and load
  output logic              trg_o,
  output logic [PLEN_W-1:0] post_len_o,
  output logic              capture_o,
  output logic              busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_WAIT = 2'd1,
    ST_CAPT = 2'd2
  } state_t;

  state_t   state_q;
  acq_cfg_t cfg_q;
  logic     trg_sel;

  //////////////////////////////////////////////////////////////////////
  // trigger selection
  //////////////////////////////////////////////////////////////////////

  // the source not selected is ignored
  assign trg_sel = (cfg_q.trg_src == TRG_EXT) ? trg_ext_i : trg_sw_i;

  // trigger counts only while waiting
  // stop in the same cycle wins
  assign trg_o = (state_q == ST_WAIT) && trg_sel && !stop_i;

  // zero length captures one sample
  assign post_len_o = (cfg_q.post_len == '0) ? PLEN_W'(1) : cfg_q.post_len;

  assign capture_o = (state_q == ST_CAPT);
  assign busy_o    = (state_q != ST_IDLE);

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q <= ST_IDLE;
      cfg_q   <= '0;
    end else if (stop_i) begin
      // abort from any state
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // arm takes a fresh configuration
          if (arm_i) begin
            state_q <= ST_WAIT;
            cfg_q   <= acq_cfg_i;
          end
        end
        ST_WAIT: begin
          if (trg_o) begin
            state_q <= ST_CAPT;
          end
        end
        ST_CAPT: begin
          // last sample is this cycle, idle in the next
          if (last_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

endmodule : acq_fsm

`default_nettype wire

// ==== src/osc_top.sv ====
`default_nettype none

module osc_top
  import osc_pkg::*;
#(
  // time stamp width
  parameter int unsigned TW     = 64,
  // external trigger debounce
  parameter int unsigned DB_LEN = 16,
  parameter int unsigned DB_CW  = 8
) (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // ADC
  input  logic [ADC_RAW_W-1:0] adc_dat_i,
  // settings
  input  cal_t                 cal_i,
  input  acq_cfg_t             acq_cfg_i,
  // control strobes
  input  logic                 arm_i,
  input  logic                 stop_i,
  input  logic                 trg_sw_i,
  // asynchronous external trigger
  input  logic                 trg_ext_i,
  // sample stream
  output smp_t                 smp_o,
  output logic                 smp_vld_o,
  output logic                 smp_last_o,
  // status
  output logic                 busy_o,
  output logic [TW-1:0]        trg_ts_o
);

  logic              ext_trg;
  logic              acq_trg;
  logic [PLEN_W-1:0] post_len;
  logic              capture;
  logic              cnt_last;

  //////////////////////////////////////////////////////////////////////
  // ADC front end
  //////////////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_i (
    .adc_clk   (adc_clk  ),
    .top_rst   (top_rst  ),
    .adc_dat_i (adc_dat_i),
    .cal_i     (cal_i    ),
    .smp_o     (smp_o    )
  );

  //////////////////////////////////////////////////////////////////////
  // external trigger
  //////////////////////////////////////////////////////////////////////

  debounce #(
    .DB_LEN (DB_LEN),
    .DB_CW  (DB_CW )
  ) debounce_i (
    .adc_clk (adc_clk  ),
    .top_rst (top_rst  ),
    .din_i   (trg_ext_i),
    .pos_o   (ext_trg  )
  );

  //////////////////////////////////////////////////////////////////////
  // acquisition
  //////////////////////////////////////////////////////////////////////

  acq_fsm acq_fsm_i (
    .adc_clk    (adc_clk  ),
    .top_rst    (top_rst  ),
    .arm_i      (arm_i    ),
    .stop_i     (stop_i   ),
    .trg_sw_i   (trg_sw_i ),
    .trg_ext_i  (ext_trg  ),
    .acq_cfg_i  (acq_cfg_i),
    .last_i     (cnt_last ),
    .trg_o      (acq_trg  ),
    .post_len_o (post_len ),
    .capture_o  (capture  ),
    .busy_o     (busy_o   )
  );

  acq_counter #(
    .TW (TW)
  ) acq_counter_i (
    .adc_clk    (adc_clk ),
    .top_rst    (top_rst ),
    .trg_i      (acq_trg ),
    .post_len_i (post_len),
    .cnt_en_i   (capture ),
    .trg_ts_o   (trg_ts_o),
    .last_o     (cnt_last)
  );

  // valid for the whole capture
  assign smp_vld_o  = capture;
  // counter flag only counts inside a capture
  assign smp_last_o = capture & cnt_last;

endmodule : osc_top

`default_nettype wire

// ==== verif/osc_assert.sv ====
`default_nettype none

module osc_assert (
  input logic adc_clk,
  input logic top_rst,
  input logic smp_vld_o,
  input logic smp_last_o,
  input logic busy_o
);

  timeunit 1ns;
  timeprecision 1ns;

  //////////////////////////////////////////////////////////////////////
  // sample stream
  //////////////////////////////////////////////////////////////////////

  // capture and busy both end right after the last sample
  a_last_vld : assert property (
    @(posedge adc_clk) disable iff (top_rst) smp_last_o |=> (!smp_vld_o && !busy_o)
  ) else $error("capture still running after smp_last_o");

  // samples only follow an armed cycle
  a_vld_busy : assert property (
    @(posedge adc_clk) disable iff (top_rst) smp_vld_o |-> $past(busy_o)
  ) else $error("smp_vld_o high without a preceding busy cycle");

  //////////////////////////////////////////////////////////////////////
  // reset
  //////////////////////////////////////////////////////////////////////

  a_rst_quiet : assert property (
    @(posedge adc_clk) top_rst |-> (!busy_o && !smp_vld_o)
  ) else $error("busy_o or smp_vld_o high during reset");

endmodule : osc_assert

`default_nettype wire

// ==== verif/osc_tb.sv ====
`default_nettype none

module osc_tb
  import osc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  //////////////////////////////////////////////////////////////////////
  // setup
  //////////////////////////////////////////////////////////////////////

  localparam int DB_LEN   = 16;
  // samples for the external trigger capture
  localparam int EXT_LEN  = 4;
  // cycles the long external level is held
  localparam int EXT_HOLD = 40;

  // calibrated sample range
  localparam longint SMP_HI = 8191;
  localparam longint SMP_LO = -8192;

  // cycle budget of each test, watchdog allows twice the sum
  localparam int BUD_RESET = 10;
  localparam int BUD_CAL   = 160;
  localparam int BUD_LEN   = 40;
  localparam int BUD_TS    = 80;
  localparam int BUD_EXT   = 140;
  localparam int BUD_CTRL  = 80;
  localparam int WD_CYCLES = 2 * (BUD_RESET + BUD_CAL + BUD_LEN + BUD_TS + BUD_EXT + BUD_CTRL);

  logic                 adc_clk = 1'b0;
  logic                 top_rst;
  logic [ADC_RAW_W-1:0] adc_dat_i = '0;
  cal_t                 cal_i;
  acq_cfg_t             acq_cfg_i;
  logic                 arm_i;
  logic                 stop_i;
  logic                 trg_sw_i;
  logic                 trg_ext_i;
  smp_t                 smp_o;
  logic                 smp_vld_o;
  logic                 smp_last_o;
  logic                 busy_o;
  logic [63:0]          trg_ts_o;

  // ADC word history, [3] is the word behind the current smp_o
  logic [ADC_RAW_W-1:0] hist [0:3];
  logic [31:0]          lfsr_q = 32'h7cd2;
  // cycles since reset, tracks the time stamp counter
  longint               cyc;
  // saturated samples seen
  int                   sat_hi;
  int                   sat_lo;

  always #50 adc_clk = ~adc_clk;

  osc_top #(
    .TW     (64    ),
    .DB_LEN (DB_LEN),
    .DB_CW  (8     )
  ) dut_i (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .adc_dat_i  (adc_dat_i ),
    .cal_i      (cal_i     ),
    .acq_cfg_i  (acq_cfg_i ),
    .arm_i      (arm_i     ),
    .stop_i     (stop_i    ),
    .trg_sw_i   (trg_sw_i  ),
    .trg_ext_i  (trg_ext_i ),
    .smp_o      (smp_o     ),
    .smp_vld_o  (smp_vld_o ),
    .smp_last_o (smp_last_o),
    .busy_o     (busy_o    ),
    .trg_ts_o   (trg_ts_o  )
  );

  bind osc_top osc_assert osc_assert_i (
    .adc_clk    (adc_clk   ),
    .top_rst    (top_rst   ),
    .smp_vld_o  (smp_vld_o ),
    .smp_last_o (smp_last_o),
    .busy_o     (busy_o    )
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus sources and models
  //////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, output from the top bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // new random ADC word every cycle, 16 LFSR steps each
  always @(posedge adc_clk) begin : adc_drive
    logic [ADC_RAW_W-1:0] w;
    w = '0;
    for (int i = 0; i < ADC_RAW_W; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[ADC_RAW_W-2:0], lfsr_q[31]};
    end
    adc_dat_i <= w;
    hist[0]   <= w;
    hist[1]   <= hist[0];
    hist[2]   <= hist[1];
    hist[3]   <= hist[2];
  end

  // 0 in the first cycle out of reset
  always @(posedge adc_clk) begin
    if (top_rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // expected sample for one raw word
  function automatic longint cal_model(input logic [ADC_RAW_W-1:0] w, input cal_t c);
    logic [13:0] raw_bits;
    longint      raw;
    longint      acc;
    // sign kept, bits 14:2 inverted
    raw_bits = {w[15], ~w[14:2]};
    raw = longint'(raw_bits);
    if (raw_bits[13]) begin
      raw = raw - 16384;
    end
    // floor shift by the binary point
    acc = (raw * longint'(c.mul)) >>> 14;
    acc = acc + longint'(c.sum);
    if (acc > SMP_HI) begin
      acc = SMP_HI;
    end else if (acc < SMP_LO) begin
      acc = SMP_LO;
    end
    return acc;
  endfunction

  function automatic acq_cfg_t make_cfg(input trg_src_t src, input logic [PLEN_W-1:0] len);
    return '{trg_src: src, post_len: len};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input longint got, input longint exp);
    if (got != exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic fail_now(input string what);
    $display("error at t=%0t: %s", $time, what);
    $display("TB FAILED");
    $fatal(1, "%s", what);
  endtask

  // n cycles with no sample out
  task automatic idle_check(input int n, input logic exp_busy);
    repeat (n) begin
      @(negedge adc_clk);
      check("smp_vld_o", longint'(smp_vld_o), 0);
      check("busy_o", longint'(busy_o), longint'(exp_busy));
    end
  endtask

  task automatic set_cal(input cal_mul_t mul, input smp_t sum);
    @(posedge adc_clk);
    cal_i <= '{mul: mul, sum: sum};
    // let the pipeline fill with the new setting
    repeat (4) @(posedge adc_clk);
  endtask

  // config is changed right after arm, must not matter
  task automatic arm_acq(input acq_cfg_t cfg);
    @(posedge adc_clk);
    arm_i     <= 1'b1;
    acq_cfg_i <= cfg;
    @(negedge adc_clk);
    check("busy_o", longint'(busy_o), 0);
    @(posedge adc_clk);
    arm_i     <= 1'b0;
    acq_cfg_i <= acq_cfg_t'(~cfg);
    @(negedge adc_clk);
    check("busy_o", longint'(busy_o), 1);
  endtask

  // starts at the negedge of the first expected valid cycle
  task automatic collect_capture(input int exp_len, input longint exp_ts, input bit poke_arm);
    int     n;
    longint exp_smp;
    n = 0;
    while (smp_vld_o) begin
      n = n + 1;
      if (n > exp_len) begin
        fail_now("smp_vld_o stayed high past the capture length");
      end
      exp_smp = cal_model(hist[3], cal_i);
      check("smp_o", longint'(smp_o), exp_smp);
      check("smp_last_o", longint'(smp_last_o), longint'(n == exp_len));
      check("busy_o", longint'(busy_o), 1);
      if (exp_smp == SMP_HI) begin
        sat_hi = sat_hi + 1;
      end
      if (exp_smp == SMP_LO) begin
        sat_lo = sat_lo + 1;
      end
      @(posedge adc_clk);
      // stray arm in the middle of the capture
      arm_i <= poke_arm && (n == 2);
      @(negedge adc_clk);
    end
    check("capture length", longint'(n), longint'(exp_len));
    check("busy_o", longint'(busy_o), 0);
    check("trg_ts_o", longint'(trg_ts_o), exp_ts);
  endtask

  task automatic run_sw_capture(input acq_cfg_t cfg, input int exp_len, input bit poke_arm);
    longint ts;
    arm_acq(cfg);
    @(posedge adc_clk);
    trg_sw_i <= 1'b1;
    @(negedge adc_clk);
    ts = cyc;
    check("smp_vld_o", longint'(smp_vld_o), 0);
    @(posedge adc_clk);
    trg_sw_i <= 1'b0;
    @(negedge adc_clk);
    check("smp_vld_o", longint'(smp_vld_o), 1);
    collect_capture(exp_len, ts, poke_arm);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge adc_clk);
    check("busy_o", longint'(busy_o), 0);
    check("smp_vld_o", longint'(smp_vld_o), 0);
    check("smp_last_o", longint'(smp_last_o), 0);
    check("trg_ts_o", longint'(trg_ts_o), 0);
  endtask

  task automatic test_calibration();
    // unity gain
    set_cal(16'sd16384, 14'sd0);
    run_sw_capture(make_cfg(TRG_SW, 16'd16), 16, 1'b0);
    // half gain with offset
    set_cal(16'sd8192, 14'sd100);
    run_sw_capture(make_cfg(TRG_SW, 16'd16), 16, 1'b0);
    // near 2x drives both rails
    set_cal(16'sh7fff, 14'sd0);
    sat_hi = 0;
    sat_lo = 0;
    run_sw_capture(make_cfg(TRG_SW, 16'd64), 64, 1'b0);
    if (sat_hi == 0 || sat_lo == 0) begin
      fail_now("large gain never reached both saturation limits");
    end
    set_cal(16'sd16384, 14'sd0);
  endtask

  task automatic test_capture_length();
    run_sw_capture(make_cfg(TRG_SW, 16'd1), 1, 1'b0);
    run_sw_capture(make_cfg(TRG_SW, 16'd5), 5, 1'b0);
    // zero acts as one
    run_sw_capture(make_cfg(TRG_SW, 16'd0), 1, 1'b0);
  endtask

  task automatic test_trigger_ts();
    idle_check(37, 1'b0);
    run_sw_capture(make_cfg(TRG_SW, 16'd3), 3, 1'b0);
    idle_check(11, 1'b0);
    run_sw_capture(make_cfg(TRG_SW, 16'd3), 3, 1'b0);
  endtask

  task automatic test_ext_trigger();
    int w;
    int held;
    arm_acq(make_cfg(TRG_EXT, 16'(EXT_LEN)));
    // 10 cycle glitch, sw strobe in the middle
    @(posedge adc_clk);
    trg_ext_i <= 1'b1;
    repeat (4) @(posedge adc_clk);
    trg_sw_i <= 1'b1;
    @(posedge adc_clk);
    trg_sw_i <= 1'b0;
    repeat (5) @(posedge adc_clk);
    trg_ext_i <= 1'b0;
    idle_check(DB_LEN + 8, 1'b1);
    // long level
    @(posedge adc_clk);
    trg_ext_i <= 1'b1;
    w = 0;
    @(negedge adc_clk);
    while (!smp_vld_o) begin
      if (w > DB_LEN + 4) begin
        fail_now("debounced external level started no capture in time");
      end
      @(negedge adc_clk);
      w = w + 1;
    end
    if (w < DB_LEN + 3) begin
      fail_now("external level started a capture before the debounce time");
    end
    // trigger was the cycle before the first sample
    collect_capture(EXT_LEN, cyc - 1, 1'b0);
    held = w + EXT_LEN + 1;
    // two cycles left for the re-arm below
    while (held < EXT_HOLD - 2) begin
      @(negedge adc_clk);
      check("smp_vld_o", longint'(smp_vld_o), 0);
      check("busy_o", longint'(busy_o), 0);
      held = held + 1;
    end
    // falling edge while armed starts nothing
    arm_acq(make_cfg(TRG_EXT, 16'(EXT_LEN)));
    @(posedge adc_clk);
    trg_ext_i <= 1'b0;
    idle_check(DB_LEN + 8, 1'b1);
    @(posedge adc_clk);
    stop_i <= 1'b1;
    @(posedge adc_clk);
    stop_i <= 1'b0;
    idle_check(2, 1'b0);
  endtask

  task automatic test_control();
    // trigger while idle
    @(posedge adc_clk);
    trg_sw_i <= 1'b1;
    @(posedge adc_clk);
    trg_sw_i <= 1'b0;
    idle_check(4, 1'b0);
    // arm during capture, length must stay 8
    run_sw_capture(make_cfg(TRG_SW, 16'd8), 8, 1'b1);
    idle_check(3, 1'b0);
    // stop while waiting
    arm_acq(make_cfg(TRG_SW, 16'd4));
    idle_check(2, 1'b1);
    @(posedge adc_clk);
    stop_i <= 1'b1;
    @(negedge adc_clk);
    check("busy_o", longint'(busy_o), 1);
    @(posedge adc_clk);
    stop_i <= 1'b0;
    @(negedge adc_clk);
    check("busy_o", longint'(busy_o), 0);
    check("smp_vld_o", longint'(smp_vld_o), 0);
    // no longer waiting, trigger ignored
    @(posedge adc_clk);
    trg_sw_i <= 1'b1;
    @(posedge adc_clk);
    trg_sw_i <= 1'b0;
    idle_check(3, 1'b0);
    // stop during capture
    arm_acq(make_cfg(TRG_SW, 16'd20));
    @(posedge adc_clk);
    trg_sw_i <= 1'b1;
    @(posedge adc_clk);
    trg_sw_i <= 1'b0;
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    check("smp_vld_o", longint'(smp_vld_o), 1);
    @(posedge adc_clk);
    stop_i <= 1'b1;
    @(negedge adc_clk);
    check("smp_vld_o", longint'(smp_vld_o), 1);
    @(posedge adc_clk);
    stop_i <= 1'b0;
    @(negedge adc_clk);
    check("busy_o", longint'(busy_o), 0);
    check("smp_vld_o", longint'(smp_vld_o), 0);
    check("smp_last_o", longint'(smp_last_o), 0);
    idle_check(3, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    top_rst   = 1'b1;
    cal_i     = '{mul: 16'sd16384, sum: 14'sd0};
    acq_cfg_i = make_cfg(TRG_SW, 16'd1);
    arm_i     = 1'b0;
    stop_i    = 1'b0;
    trg_sw_i  = 1'b0;
    trg_ext_i = 1'b0;
    sat_hi    = 0;
    sat_lo    = 0;
    repeat (4) @(posedge adc_clk);
    top_rst <= 1'b0;
    test_reset();
    test_calibration();
    test_capture_length();
    test_trigger_ts();
    test_ext_trigger();
    test_control();
    $display("TB PASSED");
    $finish;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge adc_clk);
    $display("watchdog: run did not finish within %0d cycles", WD_CYCLES);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule : osc_tb

`default_nettype wire

// ==== sources.f ====
common/osc_pkg.sv
src/adc_frontend.sv
src/debounce.sv
acq/acq_counter.sv
acq/acq_fsm.sv
src/osc_top.sv
verif/osc_assert.sv
verif/osc_tb.sv

// ==== Makefile ====
# Verilator simulation of osc_tb

OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f sources.f \
	  --top-module osc_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vosc_tb

clean:
	rm -rf $(OBJ_DIR)
